//--- logic/audio_params.svh
// Audio tone source widths, generator steps and serial clock division
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Sample and output widths
`define AUDIO_PCM_BITS   12
`define AUDIO_DAC_BITS   4
`define AUDIO_LED_BITS   8
`define AUDIO_WORD_BITS  24

// I2S framing
`define AUDIO_BCK_DIV    4        // Clocks per bck period
`define AUDIO_SLOT_BITS  32       // Bck periods per channel slot

// Triangle generator
`define AUDIO_TRI_STEP   64
`define AUDIO_TRI_PEAK   (1984)   // 31 steps from zero to peak

// Sine generator, quarter table of 2**5 entries
`define AUDIO_SINE_QBITS 5

`endif

//--- logic/audio_pkg.sv
// Audio package with the sample type and the two-view 24-bit audio word
`include "audio_params.svh"

package audio_pkg;

    // Signed sample as produced by the generators
    typedef logic signed [`AUDIO_PCM_BITS-1:0] pcm_t;

    // Field view of a 24-bit audio word
    typedef struct packed {
        logic                                          sext; // Copy of the sign
        pcm_t                                          pcm;
        logic [`AUDIO_WORD_BITS-`AUDIO_PCM_BITS-2:0]   pad;  // Always zero
    } audio_fields_t;

    // Same word, packed by fields and shifted out raw
    typedef union packed {
        audio_fields_t                f;
        logic [`AUDIO_WORD_BITS-1:0]  raw;
    } audio_word_u;

endpackage

//--- logic/sample_if.sv
// Sample bus carrying one left/right word pair per frame to the output blocks
`timescale 1ns/1ps

interface sample_if
    import audio_pkg::*;
();
    audio_word_u left;          // Selected wave
    audio_word_u right;         // Sine only
    pcm_t        left_pcm;      // Plain copy for the PWM path
    logic        sample_valid;  // One-cycle strobe per frame

    modport ctrl (
        output left,
        output right,
        output left_pcm,
        output sample_valid
    );

    modport sink (
        input left,
        input right,
        input left_pcm,
        input sample_valid
    );

endinterface

//--- logic/tone_gen.sv
// Tone generator with a triangle counter and a quarter-table sine
`timescale 1ns/1ps
`include "audio_params.svh"

module tone_gen
    import audio_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic step,
    output pcm_t tri_pcm,
    output pcm_t sine_pcm
);

    localparam int QB    = `AUDIO_SINE_QBITS;
    localparam int PH_W  = QB + 2;                // Two quadrant bits on top
    localparam int MAG_W = `AUDIO_PCM_BITS - 1;

    logic             tri_up;
    pcm_t             tri_nx;
    logic [PH_W-1:0]  phase;
    logic [PH_W-1:0]  phase_nx;
    logic [QB:0]      mirror_idx;
    logic [MAG_W-1:0] mag;
    pcm_t             mag_s;
    pcm_t             sine_nx;

    // 2047 * sin(2*pi*i/128) for the first quadrant
    function automatic logic [MAG_W-1:0] quarter_lut(input logic [QB-1:0] idx);
        logic [MAG_W-1:0] v;
        case (idx)
            5'd0:    v = 11'd0;
            5'd1:    v = 11'd100;
            5'd2:    v = 11'd201;
            5'd3:    v = 11'd300;
            5'd4:    v = 11'd399;
            5'd5:    v = 11'd497;
            5'd6:    v = 11'd594;
            5'd7:    v = 11'd690;
            5'd8:    v = 11'd783;
            5'd9:    v = 11'd875;
            5'd10:   v = 11'd965;
            5'd11:   v = 11'd1052;
            5'd12:   v = 11'd1137;
            5'd13:   v = 11'd1219;
            5'd14:   v = 11'd1299;
            5'd15:   v = 11'd1375;
            5'd16:   v = 11'd1447;
            5'd17:   v = 11'd1517;
            5'd18:   v = 11'd1582;
            5'd19:   v = 11'd1644;
            5'd20:   v = 11'd1702;
            5'd21:   v = 11'd1756;
            5'd22:   v = 11'd1805;
            5'd23:   v = 11'd1850;
            5'd24:   v = 11'd1891;
            5'd25:   v = 11'd1927;
            5'd26:   v = 11'd1959;
            5'd27:   v = 11'd1986;
            5'd28:   v = 11'd2008;
            5'd29:   v = 11'd2025;
            5'd30:   v = 11'd2037;
            default: v = 11'd2045;
        endcase
        return v;
    endfunction

    // Triangle moves one step up or down
    assign tri_nx = tri_up ? tri_pcm + pcm_t'(`AUDIO_TRI_STEP)
                           : tri_pcm - pcm_t'(`AUDIO_TRI_STEP);

    // Sine phase and quadrant folding
    assign phase_nx   = phase + 1'b1;
    assign mirror_idx = (QB+1)'(1 << QB) - {1'b0, phase_nx[QB-1:0]}; // Falling quarter

    always_comb begin
        if (!phase_nx[QB]) begin
            mag = quarter_lut(phase_nx[QB-1:0]);
        end else if (mirror_idx[QB]) begin
            mag = '1;                                  // Crest lies past the table end
        end else begin
            mag = quarter_lut(mirror_idx[QB-1:0]);
        end
    end

    assign mag_s   = {1'b0, mag};
    assign sine_nx = phase_nx[QB+1] ? -mag_s : mag_s;  // Second half is negative

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tri_pcm  <= '0;
            tri_up   <= 1'b1;
            phase    <= '0;
            sine_pcm <= '0;
        end else if (step) begin
            tri_pcm  <= tri_nx;
            phase    <= phase_nx;
            sine_pcm <= sine_nx;
            // Turn around at either peak
            if (tri_nx == pcm_t'(`AUDIO_TRI_PEAK) || tri_nx == pcm_t'(-`AUDIO_TRI_PEAK)) begin
                tri_up <= ~tri_up;
            end
        end
    end

endmodule

//--- logic/audio_ctrl.sv
// Audio control, steps the generators each frame and publishes the sample pair
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_ctrl
    import audio_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wave_sel,
    input  logic                       frame_tick,
    input  pcm_t                       tri_pcm,
    input  pcm_t                       sine_pcm,
    output logic                       step,
    output logic [`AUDIO_LED_BITS-1:0] led,
    sample_if.ctrl                     smp
);

    logic        step_d;     // Generators have settled here
    pcm_t        sel_pcm;
    audio_word_u left_w;
    audio_word_u right_w;

    // High picks the triangle, low the sine
    assign sel_pcm = wave_sel ? tri_pcm : sine_pcm;

    // Pack both channels through the field view
    always_comb begin
        left_w.f.sext  = sel_pcm[`AUDIO_PCM_BITS-1];
        left_w.f.pcm   = sel_pcm;
        left_w.f.pad   = '0;
        right_w.f.sext = sine_pcm[`AUDIO_PCM_BITS-1];
        right_w.f.pcm  = sine_pcm;
        right_w.f.pad  = '0;
    end

    // Strobe chain frame_tick -> step -> step_d -> sample_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step             <= 1'b0;
            step_d           <= 1'b0;
            smp.sample_valid <= 1'b0;
        end else begin
            step             <= frame_tick;
            step_d           <= step;
            smp.sample_valid <= step_d;
        end
    end

    // Sample registers, zero so the outputs start silent
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            smp.left     <= '0;
            smp.right    <= '0;
            smp.left_pcm <= '0;
            led          <= '0;
        end else if (step_d) begin
            smp.left     <= left_w;
            smp.right    <= right_w;
            smp.left_pcm <= sel_pcm;
            led          <= sel_pcm[`AUDIO_PCM_BITS-1 -: `AUDIO_LED_BITS]; // Upper bits
        end
    end

endmodule

//--- logic/pwm_dac.sv
// PWM DAC, first-order error feedback from 12-bit signed samples to 4 bits
`timescale 1ns/1ps
`include "audio_params.svh"

module pwm_dac
    import audio_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  pcm_t                       pcm,
    output logic [`AUDIO_DAC_BITS-1:0] dac
);

    localparam int PCM_W = `AUDIO_PCM_BITS;
    localparam int RES_W = `AUDIO_PCM_BITS - `AUDIO_DAC_BITS;

    logic [PCM_W-1:0] u;        // Offset binary
    logic [RES_W-1:0] residue;  // Fraction carried to the next clock
    logic [PCM_W:0]   acc;

    // Flip the sign bit, same as adding half scale
    assign u   = {~pcm[PCM_W-1], pcm[PCM_W-2:0]};
    assign acc = (PCM_W+1)'(u) + (PCM_W+1)'(residue);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dac     <= '0;
            residue <= '0;
        end else if (acc[PCM_W]) begin
            // Near full scale the sum exceeds 4 bits, hold the top code
            dac     <= '1;
            residue <= '1;
        end else begin
            dac     <= acc[PCM_W-1 -: `AUDIO_DAC_BITS];
            residue <= acc[RES_W-1:0];
        end
    end

endmodule

//--- logic/i2s_tx.sv
// I2S transmitter, bit and word clocks with a 24-in-32 MSB-first serializer
`timescale 1ns/1ps
`include "audio_params.svh"

module i2s_tx (
    input  logic   clk,
    input  logic   rst_n,
    sample_if.sink smp,
    output logic   frame_tick,
    output logic   bck,
    output logic   lrck,
    output logic   din
);

    localparam int DIV_W      = $clog2(`AUDIO_BCK_DIV);
    localparam int FRAME_CLKS = 2 * `AUDIO_SLOT_BITS * `AUDIO_BCK_DIV;
    localparam int CNT_W      = $clog2(FRAME_CLKS);
    localparam int PAD_W      = `AUDIO_SLOT_BITS - `AUDIO_WORD_BITS;

    logic [CNT_W-1:0]            clk_cnt;
    logic                        bit_edge;  // Last clock of a bck period
    logic [`AUDIO_WORD_BITS-1:0] hold_l;
    logic [`AUDIO_WORD_BITS-1:0] hold_r;
    logic [`AUDIO_SLOT_BITS-1:0] shift_l;
    logic [`AUDIO_SLOT_BITS-1:0] shift_r;

    // Clocks come straight off the counter bits
    assign bck      = clk_cnt[DIV_W-1];
    assign lrck     = clk_cnt[CNT_W-1];     // Low for left
    assign bit_edge = (clk_cnt[DIV_W-1:0] == DIV_W'(`AUDIO_BCK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_cnt    <= '0;
            frame_tick <= 1'b0;
        end else begin
            clk_cnt    <= clk_cnt + 1'b1;
            frame_tick <= &clk_cnt;         // High as lrck falls
        end
    end

    // Capture the new pair mid-frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_l <= '0;
            hold_r <= '0;
        end else if (smp.sample_valid) begin
            hold_l <= smp.left.raw;
            hold_r <= smp.right.raw;
        end
    end

    // Load both slots at frame start, then shift one bit per bck
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_l <= '0;
            shift_r <= '0;
            din     <= 1'b0;
        end else if (frame_tick) begin
            shift_l <= {hold_l, {PAD_W{1'b0}}};
            shift_r <= {hold_r, {PAD_W{1'b0}}};
        end else if (bit_edge) begin
            // Lands on the bck fall, one period late
            if (!lrck) begin
                din     <= shift_l[`AUDIO_SLOT_BITS-1];
                shift_l <= shift_l << 1;
            end else begin
                din     <= shift_r[`AUDIO_SLOT_BITS-1];
                shift_r <= shift_r << 1;
            end
        end
    end

endmodule

//--- logic/audio_top.sv
// Audio tone source top, triangle or sine to I2S, PWM and LED bar
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_top
    import audio_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wave_sel,  // High for triangle on left
    output logic [`AUDIO_DAC_BITS-1:0] dac,
    output logic [`AUDIO_LED_BITS-1:0] led,
    output logic                       bck,
    output logic                       lrck,
    output logic                       din
);

    logic frame_tick;
    logic step;
    pcm_t tri_pcm;
    pcm_t sine_pcm;

    sample_if smp_bus ();

    audio_ctrl audio_ctrl_instance (
        .clk       (clk),
        .rst_n     (rst_n),
        .wave_sel  (wave_sel),
        .frame_tick(frame_tick),
        .tri_pcm   (tri_pcm),
        .sine_pcm  (sine_pcm),
        .step      (step),
        .led       (led),
        .smp       (smp_bus.ctrl)
    );

    tone_gen tone_gen_instance (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .tri_pcm (tri_pcm),
        .sine_pcm(sine_pcm)
    );

    // Headphone output follows the left channel
    pwm_dac pwm_dac_instance (
        .clk  (clk),
        .rst_n(rst_n),
        .pcm  (smp_bus.left_pcm),
        .dac  (dac)
    );

    i2s_tx i2s_tx_instance (
        .clk       (clk),
        .rst_n     (rst_n),
        .smp       (smp_bus.sink),
        .frame_tick(frame_tick),
        .bck       (bck),
        .lrck      (lrck),
        .din       (din)
    );

endmodule

//--- testbench/audio_tb.sv
// Audio tone source testbench that deserializes I2S and checks samples, LED bar and PWM level
`timescale 1ns/1ps

module audio_tb;

    localparam int      NFRAMES    = 260;
    localparam int      SINE_END   = 130;         // First frame carrying the triangle
    localparam int      FRAME_CLKS = 256;
    localparam int      HALF_BCKS  = 32;
    localparam int      DAC_FULL   = 15 * 256;    // Sum with dac pinned at its top code
    localparam realtime TIMEOUT_NS = (NFRAMES + 4) * FRAME_CLKS * 10.0 + 8 * 10.0;

    localparam int T_RESET  = 0;
    localparam int T_TIMING = 1;
    localparam int T_SINE   = 2;
    localparam int T_TRI    = 3;
    localparam int T_LEDPWM = 4;

    logic       clk;
    logic       rst_n;
    logic       wave_sel;
    logic [3:0] dac;
    logic [7:0] led;
    logic       bck;
    logic       lrck;
    logic       din;

    logic [23:0] td [0:3*NFRAMES-1];   // Mode, left word, right word per frame
    int          errs [5];
    int          checks;
    string       names [5] = '{"reset", "frame_timing", "sine_mode", "triangle_mode", "led_pwm"};

    logic        prev_bck;
    logic        prev_lrck;
    logic [63:0] sr;                    // Last 64 bits off the serial line
    logic [23:0] led_word;
    int          frame_no;
    int          frames_done;
    int          clks;                  // Clocks since the last lrck fall
    int          rises;                 // Bck rises in the current half
    int          dac_sum;
    int          win_cnt;
    int          win_frame;
    logic        in_win;

    audio_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .wave_sel(wave_sel),
        .dac     (dac),
        .led     (led),
        .bck     (bck),
        .lrck    (lrck),
        .din     (din)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [23:0] left_of(input int k);
        return td[3*k+1];
    endfunction

    function automatic logic [23:0] right_of(input int k);
        return td[3*k+2];
    endfunction

    function automatic logic mode_of(input int k);
        return td[3*k][0];
    endfunction

    task automatic report_test(input int t);
        $display("%-14s %s, %0d errors", names[t], (errs[t] == 0) ? "ok" : "FAILED", errs[t]);
    endtask

    task automatic check_reset_out(input string name, input logic [7:0] got);
        checks++;
        if (got !== 8'h00) begin
            $display("FAIL %s after reset: got %h, expected 00", name, got);
            errs[T_RESET]++;
        end
    endtask

    task automatic check_frame(input int k, input logic [63:0] bits);
        int t;
        t = (k < SINE_END) ? T_SINE : T_TRI;
        checks += 4;
        if (bits[63:40] !== left_of(k)) begin
            $display("FAIL frame %0d left: got %h, expected %h", k, bits[63:40], left_of(k));
            errs[t]++;
        end
        if (bits[31:8] !== right_of(k)) begin
            $display("FAIL frame %0d right: got %h, expected %h", k, bits[31:8], right_of(k));
            errs[t]++;
        end
        if (bits[39:32] !== 8'h00) begin
            $display("FAIL frame %0d left pad: got %h, expected 00", k, bits[39:32]);
            errs[t]++;
        end
        if (bits[7:0] !== 8'h00) begin
            $display("FAIL frame %0d right pad: got %h, expected 00", k, bits[7:0]);
            errs[t]++;
        end
    endtask

    // Dac sum over 256 clocks equals the offset-binary level until code 15 is pinned
    task automatic check_dac(input int k, input int sum);
        logic [23:0] w;
        int          pcm;
        int          expect_sum;
        w          = left_of(k);
        pcm        = $signed(w[22:11]);
        expect_sum = pcm + 2048;
        if (expect_sum > DAC_FULL) expect_sum = DAC_FULL;
        checks++;
        if (sum > expect_sum + 1 || sum < expect_sum - 1) begin
            $display("FAIL frame %0d dac sum: got %h, expected %h", k, sum, expect_sum);
            errs[T_LEDPWM]++;
        end
    endtask

    // Serial monitor sampling the cycle that just ended
    always @(posedge clk) begin
        if (rst_n) begin
            clks = clks + 1;
            if (!lrck && prev_lrck) begin
                if (frame_no >= 0) begin
                    checks += 2;
                    if (clks != FRAME_CLKS) begin
                        $display("FAIL lrck period: got %h, expected %h", clks, FRAME_CLKS);
                        errs[T_TIMING]++;
                    end
                    if (rises != HALF_BCKS) begin
                        $display("FAIL bck right half: got %h, expected %h", rises, HALF_BCKS);
                        errs[T_TIMING]++;
                    end
                end
                frame_no = frame_no + 1;
                clks     = 0;
                rises    = 0;
                if (frame_no + 1 < NFRAMES) wave_sel <= mode_of(frame_no + 1);
            end
            if (lrck && !prev_lrck) begin
                if (frame_no >= 0) begin
                    checks++;
                    if (rises != HALF_BCKS) begin
                        $display("FAIL bck left half: got %h, expected %h", rises, HALF_BCKS);
                        errs[T_TIMING]++;
                    end
                end
                if (frame_no >= 0 && frame_no + 1 < NFRAMES) begin
                    led_word = left_of(frame_no + 1);
                    checks++;
                    if (led !== led_word[22:15]) begin
                        $display("FAIL led: got %h, expected %h", led, led_word[22:15]);
                        errs[T_LEDPWM]++;
                    end
                end
                rises = 0;
            end
            if (bck && !prev_bck) begin
                sr    = {sr[62:0], din};
                rises = rises + 1;
                // First rise after lrck falls takes the last bit of the previous frame
                if (!lrck && rises == 1 && frame_no >= 1) begin
                    check_frame(frame_no - 1, sr);
                    frames_done = frame_no;
                    if (frame_no == SINE_END) report_test(T_SINE);
                end
            end
            if (clks == 4 && frame_no >= 0 && frame_no + 1 < NFRAMES) begin
                in_win    = 1'b1;
                win_frame = frame_no + 1;
                dac_sum   = 0;
                win_cnt   = 0;
            end
            if (in_win) begin
                dac_sum = dac_sum + dac;
                win_cnt = win_cnt + 1;
                if (win_cnt == FRAME_CLKS) begin
                    check_dac(win_frame, dac_sum);
                    in_win = 1'b0;
                end
            end
            prev_bck  = bck;
            prev_lrck = lrck;
        end
    end

    initial begin
        int total;
        rst_n       = 1'b0;
        wave_sel    = 1'b0;
        prev_bck    = 1'b0;
        prev_lrck   = 1'b0;
        sr          = '0;
        frame_no    = -1;
        frames_done = 0;
        clks        = 0;
        rises       = 0;
        in_win      = 1'b0;
        $readmemh("testbench/audio_testdata.txt", td);
        if ($isunknown(td[3*NFRAMES-1])) begin
            $display("The data file did not supply all expected frames");
            $display("Test failed");
        end else begin
            repeat (7) @(posedge clk);
            @(negedge clk);
            check_reset_out("bck", {7'd0, bck});
            check_reset_out("lrck", {7'd0, lrck});
            check_reset_out("din", {7'd0, din});
            check_reset_out("dac", {4'd0, dac});
            check_reset_out("led", led);
            @(posedge clk);
            rst_n <= 1'b1;
            report_test(T_RESET);
            wait (frames_done == NFRAMES);
            report_test(T_TIMING);
            report_test(T_TRI);
            report_test(T_LEDPWM);
            total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
            $display("Checks: %0d, errors: %0d", checks, total);
            if (total == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run stopped by the watchdog, %0d of %0d frames checked", frames_done, NFRAMES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- testbench/audio_testdata.txt
// Per frame: mode (1 = triangle on left), expected left word, expected right word
// Four frames per line from frame 0; frames 0-129 sine mode, 130-259 triangle mode
0 000000 000000  0 032000 032000  0 064800 064800  0 096000 096000
0 0C7800 0C7800  0 0F8800 0F8800  0 129000 129000  0 159000 159000
0 187800 187800  0 1B5800 1B5800  0 1E2800 1E2800  0 20E000 20E000
0 238800 238800  0 261800 261800  0 289800 289800  0 2AF800 2AF800
0 2D3800 2D3800  0 2F6800 2F6800  0 317000 317000  0 336000 336000
0 353000 353000  0 36E000 36E000  0 386800 386800  0 39D000 39D000
0 3B1800 3B1800  0 3C3800 3C3800  0 3D3800 3D3800  0 3E1000 3E1000
0 3EC000 3EC000  0 3F4800 3F4800  0 3FA800 3FA800  0 3FE800 3FE800
0 3FF800 3FF800  0 3FE800 3FE800  0 3FA800 3FA800  0 3F4800 3F4800
0 3EC000 3EC000  0 3E1000 3E1000  0 3D3800 3D3800  0 3C3800 3C3800
0 3B1800 3B1800  0 39D000 39D000  0 386800 386800  0 36E000 36E000
0 353000 353000  0 336000 336000  0 317000 317000  0 2F6800 2F6800
0 2D3800 2D3800  0 2AF800 2AF800  0 289800 289800  0 261800 261800
0 238800 238800  0 20E000 20E000  0 1E2800 1E2800  0 1B5800 1B5800
0 187800 187800  0 159000 159000  0 129000 129000  0 0F8800 0F8800
0 0C7800 0C7800  0 096000 096000  0 064800 064800  0 032000 032000
0 000000 000000  0 FCE000 FCE000  0 F9B800 F9B800  0 F6A000 F6A000
0 F38800 F38800  0 F07800 F07800  0 ED7000 ED7000  0 EA7000 EA7000
0 E78800 E78800  0 E4A800 E4A800  0 E1D800 E1D800  0 DF2000 DF2000
0 DC7800 DC7800  0 D9E800 D9E800  0 D76800 D76800  0 D50800 D50800
0 D2C800 D2C800  0 D09800 D09800  0 CE9000 CE9000  0 CCA000 CCA000
0 CAD000 CAD000  0 C92000 C92000  0 C79800 C79800  0 C63000 C63000
0 C4E800 C4E800  0 C3C800 C3C800  0 C2C800 C2C800  0 C1F000 C1F000
0 C14000 C14000  0 C0B800 C0B800  0 C05800 C05800  0 C01800 C01800
0 C00800 C00800  0 C01800 C01800  0 C05800 C05800  0 C0B800 C0B800
0 C14000 C14000  0 C1F000 C1F000  0 C2C800 C2C800  0 C3C800 C3C800
0 C4E800 C4E800  0 C63000 C63000  0 C79800 C79800  0 C92000 C92000
0 CAD000 CAD000  0 CCA000 CCA000  0 CE9000 CE9000  0 D09800 D09800
0 D2C800 D2C800  0 D50800 D50800  0 D76800 D76800  0 D9E800 D9E800
0 DC7800 DC7800  0 DF2000 DF2000  0 E1D800 E1D800  0 E4A800 E4A800
0 E78800 E78800  0 EA7000 EA7000  0 ED7000 ED7000  0 F07800 F07800
0 F38800 F38800  0 F6A000 F6A000  0 F9B800 F9B800  0 FCE000 FCE000
0 000000 000000  0 032000 032000  1 0C0000 064800  1 0E0000 096000
1 100000 0C7800  1 120000 0F8800  1 140000 129000  1 160000 159000
1 180000 187800  1 1A0000 1B5800  1 1C0000 1E2800  1 1E0000 20E000
1 200000 238800  1 220000 261800  1 240000 289800  1 260000 2AF800
1 280000 2D3800  1 2A0000 2F6800  1 2C0000 317000  1 2E0000 336000
1 300000 353000  1 320000 36E000  1 340000 386800  1 360000 39D000
1 380000 3B1800  1 3A0000 3C3800  1 3C0000 3D3800  1 3E0000 3E1000
1 3C0000 3EC000  1 3A0000 3F4800  1 380000 3FA800  1 360000 3FE800
1 340000 3FF800  1 320000 3FE800  1 300000 3FA800  1 2E0000 3F4800
1 2C0000 3EC000  1 2A0000 3E1000  1 280000 3D3800  1 260000 3C3800
1 240000 3B1800  1 220000 39D000  1 200000 386800  1 1E0000 36E000
1 1C0000 353000  1 1A0000 336000  1 180000 317000  1 160000 2F6800
1 140000 2D3800  1 120000 2AF800  1 100000 289800  1 0E0000 261800
1 0C0000 238800  1 0A0000 20E000  1 080000 1E2800  1 060000 1B5800
1 040000 187800  1 020000 159000  1 000000 129000  1 FE0000 0F8800
1 FC0000 0C7800  1 FA0000 096000  1 F80000 064800  1 F60000 032000
1 F40000 000000  1 F20000 FCE000  1 F00000 F9B800  1 EE0000 F6A000
1 EC0000 F38800  1 EA0000 F07800  1 E80000 ED7000  1 E60000 EA7000
1 E40000 E78800  1 E20000 E4A800  1 E00000 E1D800  1 DE0000 DF2000
1 DC0000 DC7800  1 DA0000 D9E800  1 D80000 D76800  1 D60000 D50800
1 D40000 D2C800  1 D20000 D09800  1 D00000 CE9000  1 CE0000 CCA000
1 CC0000 CAD000  1 CA0000 C92000  1 C80000 C79800  1 C60000 C63000
1 C40000 C4E800  1 C20000 C3C800  1 C40000 C2C800  1 C60000 C1F000
1 C80000 C14000  1 CA0000 C0B800  1 CC0000 C05800  1 CE0000 C01800
1 D00000 C00800  1 D20000 C01800  1 D40000 C05800  1 D60000 C0B800
1 D80000 C14000  1 DA0000 C1F000  1 DC0000 C2C800  1 DE0000 C3C800
1 E00000 C4E800  1 E20000 C63000  1 E40000 C79800  1 E60000 C92000
1 E80000 CAD000  1 EA0000 CCA000  1 EC0000 CE9000  1 EE0000 D09800
1 F00000 D2C800  1 F20000 D50800  1 F40000 D76800  1 F60000 D9E800
1 F80000 DC7800  1 FA0000 DF2000  1 FC0000 E1D800  1 FE0000 E4A800
1 000000 E78800  1 020000 EA7000  1 040000 ED7000  1 060000 F07800
1 080000 F38800  1 0A0000 F6A000  1 0C0000 F9B800  1 0E0000 FCE000
1 100000 000000  1 120000 032000  1 140000 064800  1 160000 096000

//--- audio_tone.f
+incdir+logic
logic/audio_pkg.sv
logic/sample_if.sv
logic/tone_gen.sv
logic/audio_ctrl.sv
logic/pwm_dac.sv
logic/i2s_tx.sv
logic/audio_top.sv
testbench/audio_tb.sv
